/* hdl/soc_cfg.svh */
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// RAM window in byte addresses
`define RAM_BASE 32'h0000_1000
`define RAM_SIZE 32'h0000_1000

// Word-interleave factor
// Power of two, 1 up to 8
`define NUM_BANKS 4

// Words per bank, follows from window size and interleave
`define BANK_DEPTH (`RAM_SIZE / 4 / `NUM_BANKS)

// Keyboard code register, read only
`define KEY_ADDR 32'h0000_2000

// Console transmit register, write only
`define UART_ADDR 32'h0000_2004

`endif

/* hdl/soc_pkg.sv */
`include "soc_cfg.svh"

package soc_pkg;

    // Full byte address on the bus
    typedef logic [`SOC_ADDR_W-1:0] addr_t;

    // One bus data word
    typedef logic [`SOC_DATA_W-1:0] data_t;

    // Bank number, one bit kept even for a single bank
    typedef logic [$clog2(`NUM_BANKS > 1 ? `NUM_BANKS : 2)-1:0] bank_idx_t;

    // Word address inside one bank
    typedef logic [$clog2(`BANK_DEPTH)-1:0] word_idx_t;

    // Decoded keyboard code, also the console character
    typedef logic [7:0] key_code_t;

    // Source of the read now in flight
    // src_none_rd answers an unmapped or console read with zero
    typedef enum logic [1:0] {
        src_none,
        src_ram,
        src_key,
        src_none_rd
    } rd_src_e;

endpackage

/* hdl/bus_decoder.sv */
`include "soc_cfg.svh"
`timescale 1ns/1ns

module bus_decoder (
    input  logic                   clock_50,
    input  logic                   key0,
    input  soc_pkg::addr_t         bus_addr,
    input  soc_pkg::data_t         bus_wdata,
    input  logic                   bus_wr,
    input  logic                   bus_rd,
    output logic [`NUM_BANKS-1:0]  bank_we,
    output logic [`NUM_BANKS-1:0]  bank_re,
    output soc_pkg::word_idx_t     bank_word,
    output soc_pkg::data_t         bank_wdata,
    output logic                   key_re,
    output logic                   uart_we,
    output soc_pkg::rd_src_e       rd_src,
    output soc_pkg::bank_idx_t     rd_bank
);

    import soc_pkg::*;

    logic      ram_sel;
    logic      key_sel;
    logic      uart_sel;
    addr_t     word_off;
    bank_idx_t bank;

    // Region compare against the address map
    assign ram_sel  = (bus_addr >= `RAM_BASE) && (bus_addr < `RAM_BASE + `RAM_SIZE);
    assign key_sel  = (bus_addr == `KEY_ADDR);
    assign uart_sel = (bus_addr == `UART_ADDR);

    // Word offset inside the RAM window
    assign word_off = (bus_addr - `RAM_BASE) >> 2;

    // Low word bits pick the bank, the rest pick the row
    assign bank      = bank_idx_t'(word_off % `NUM_BANKS);
    assign bank_word = word_idx_t'(word_off / `NUM_BANKS);

    // Write data goes to every bank, only the strobed one stores it
    assign bank_wdata = bus_wdata;

    // One-hot bank strobes
    always_comb begin
        for (int i = 0; i < `NUM_BANKS; i++) begin
            bank_we[i] = bus_wr && ram_sel && (bank == bank_idx_t'(i));
            bank_re[i] = bus_rd && ram_sel && (bank == bank_idx_t'(i));
        end
    end

    // Peripheral strobes
    assign key_re  = bus_rd && key_sel;
    assign uart_we = bus_wr && uart_sel;

    // Tag of the read, seen by the mux one cycle later
    // A new read simply overwrites the tag, so reads pipeline
    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            rd_src  <= src_none;
            rd_bank <= '0;
        end else begin
            if (!bus_rd) begin
                rd_src <= src_none;
            end else if (ram_sel) begin
                rd_src <= src_ram;
            end else if (key_sel) begin
                rd_src <= src_key;
            end else begin
                // Console address and holes read back as zero
                rd_src <= src_none_rd;
            end
            if (bus_rd) begin
                rd_bank <= bank;
            end
        end
    end

endmodule

/* hdl/ram_bank.sv */
`include "soc_cfg.svh"
`timescale 1ns/1ns

module ram_bank (
    input  logic               clock_50,
    input  logic               bank_we,
    input  logic               bank_re,
    input  soc_pkg::word_idx_t bank_word,
    input  soc_pkg::data_t     bank_wdata,
    output soc_pkg::data_t     bank_rdata
);

    import soc_pkg::*;

    // Word array, maps onto block RAM
    data_t mem [`BANK_DEPTH];

    // Contents start cleared in simulation
    initial begin
        for (int i = 0; i < `BANK_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Write port
    always_ff @(posedge clock_50) begin
        if (bank_we) begin
            mem[bank_word] <= bank_wdata;
        end
    end

    // Read register
    // Holds its word between reads
    always_ff @(posedge clock_50) begin
        if (bank_re) begin
            bank_rdata <= mem[bank_word];
        end
    end

endmodule

/* hdl/read_mux.sv */
`include "soc_cfg.svh"
`timescale 1ns/1ns

module read_mux (
    input  logic                             clock_50,
    input  logic                             key0,
    input  soc_pkg::rd_src_e                 rd_src,
    input  soc_pkg::bank_idx_t               rd_bank,
    input  soc_pkg::data_t [`NUM_BANKS-1:0]  bank_rdata,
    input  soc_pkg::data_t                   key_rdata,
    output soc_pkg::data_t                   bus_rdata,
    output logic                             rd_valid
);

    import soc_pkg::*;

    data_t sel_data;

    // Pick the answer named by the tag
    always_comb begin
        case (rd_src)
            src_ram: begin
                sel_data = bank_rdata[rd_bank];
            end
            src_key: begin
                sel_data = key_rdata;
            end
            default: begin
                // Idle, unmapped or console read
                sel_data = '0;
            end
        endcase
    end

    // Second read stage, response to the bus
    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            bus_rdata <= '0;
            rd_valid  <= 1'b0;
        end else begin
            // Any tag but none was a read strobe
            rd_valid <= (rd_src != src_none);
            if (rd_src != src_none) begin
                bus_rdata <= sel_data;
            end
        end
    end

endmodule

/* hdl/io_regs.sv */
`timescale 1ns/1ns

module io_regs (
    input  logic               clock_50,
    input  logic               key0,
    input  logic               key_valid,
    input  soc_pkg::key_code_t key_code,
    input  logic               key_re,
    output soc_pkg::data_t     key_rdata,
    input  logic               uart_we,
    input  soc_pkg::data_t     bus_wdata,
    output logic               uart_valid,
    output soc_pkg::key_code_t uart_data,
    input  logic               irq_ack,
    output logic [3:0]         irq_vector
);

    import soc_pkg::*;

    // Last code from the keyboard
    key_code_t key_q;

    logic key_set;
    logic irq_clr;

    // Latch every decoded code, zero included
    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            key_q <= '0;
        end else if (key_valid) begin
            key_q <= key_code;
        end
    end

    // Key read stage, zero-extended to a bus word
    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            key_rdata <= '0;
        end else if (key_re) begin
            key_rdata <= data_t'(key_q);
        end
    end

    // One strobe per console write
    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            uart_valid <= 1'b0;
            uart_data  <= '0;
        end else begin
            uart_valid <= uart_we;
            if (uart_we) begin
                // Low byte is the character
                uart_data <= key_code_t'(bus_wdata);
            end
        end
    end

    // Only a nonzero code raises the interrupt
    assign key_set = key_valid && (key_code != '0);
    assign irq_clr = irq_ack && (irq_vector != '0);

    // Pending interrupt, held until acknowledged
    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            irq_vector <= '0;
        end else if (irq_clr) begin
            irq_vector <= '0;
        end else if (key_set && !irq_ack) begin
            // Ack in the same cycle beats a new key
            irq_vector <= 4'd1;
        end
    end

endmodule

/* hdl/soc_bus_top.sv */
`include "soc_cfg.svh"
`timescale 1ns/1ns

module soc_bus_top (
    input  logic               clock_50,
    input  logic               key0,
    input  soc_pkg::addr_t     bus_addr,
    input  soc_pkg::data_t     bus_wdata,
    input  logic               bus_wr,
    input  logic               bus_rd,
    output soc_pkg::data_t     bus_rdata,
    output logic               rd_valid,
    input  logic               key_valid,
    input  soc_pkg::key_code_t key_code,
    output logic [3:0]         irq_vector,
    input  logic               irq_ack,
    output logic               uart_valid,
    output soc_pkg::key_code_t uart_data
);

    import soc_pkg::*;

    // Decoder to banks
    logic [`NUM_BANKS-1:0] bank_we;
    logic [`NUM_BANKS-1:0] bank_re;
    word_idx_t             bank_word;
    data_t                 bank_wdata;

    // Banks and peripherals to the read mux
    data_t [`NUM_BANKS-1:0] bank_rdata;
    data_t                  key_rdata;

    // Decoder to peripherals and mux
    logic      key_re;
    logic      uart_we;
    rd_src_e   rd_src;
    bank_idx_t rd_bank;

    bus_decoder i_bus_decoder (
        .clock_50   (clock_50),
        .key0       (key0),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_wr     (bus_wr),
        .bus_rd     (bus_rd),
        .bank_we    (bank_we),
        .bank_re    (bank_re),
        .bank_word  (bank_word),
        .bank_wdata (bank_wdata),
        .key_re     (key_re),
        .uart_we    (uart_we),
        .rd_src     (rd_src),
        .rd_bank    (rd_bank)
    );

    // Interleaved RAM banks
    for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_bank
        ram_bank i_ram_bank (
            .clock_50   (clock_50),
            .bank_we    (bank_we[g]),
            .bank_re    (bank_re[g]),
            .bank_word  (bank_word),
            .bank_wdata (bank_wdata),
            .bank_rdata (bank_rdata[g])
        );
    end

    read_mux i_read_mux (
        .clock_50   (clock_50),
        .key0       (key0),
        .rd_src     (rd_src),
        .rd_bank    (rd_bank),
        .bank_rdata (bank_rdata),
        .key_rdata  (key_rdata),
        .bus_rdata  (bus_rdata),
        .rd_valid   (rd_valid)
    );

    io_regs i_io_regs (
        .clock_50   (clock_50),
        .key0       (key0),
        .key_valid  (key_valid),
        .key_code   (key_code),
        .key_re     (key_re),
        .key_rdata  (key_rdata),
        .uart_we    (uart_we),
        .bus_wdata  (bank_wdata),
        .uart_valid (uart_valid),
        .uart_data  (uart_data),
        .irq_ack    (irq_ack),
        .irq_vector (irq_vector)
    );

endmodule

/* dv/soc_bus_assert.sv */
`include "soc_cfg.svh"
`timescale 1ns/1ns

module soc_bus_assert (
    input logic               clock_50,
    input logic               key0,
    input soc_pkg::addr_t     bus_addr,
    input logic               bus_wr,
    input logic               bus_rd,
    input soc_pkg::data_t     bus_rdata,
    input logic               rd_valid,
    input logic               uart_valid,
    input soc_pkg::key_code_t uart_data,
    input logic               irq_ack,
    input logic [3:0]         irq_vector
);

    // Running count of assertion failures
    int unsigned fail_count = 0;

    // Read response two cycles after the strobe, never otherwise
    a_rd_latency: assert property (@(posedge clock_50) disable iff (!key0)
        rd_valid == $past(bus_rd, 2))
    else begin
        $error("rd_valid does not follow bus_rd by two cycles");
        fail_count++;
    end

    // One console strobe per console write, one cycle later
    a_uart_strobe: assert property (@(posedge clock_50) disable iff (!key0)
        uart_valid == $past(bus_wr && bus_addr == `UART_ADDR))
    else begin
        $error("uart_valid does not follow a console write by one cycle");
        fail_count++;
    end

    // Acknowledge of a pending interrupt clears it
    a_irq_ack: assert property (@(posedge clock_50) disable iff (!key0)
        (irq_ack && irq_vector != 4'd0) |=> (irq_vector == 4'd0))
    else begin
        $error("irq_vector still set after an acknowledge");
        fail_count++;
    end

    // Outputs quiet while reset is held and just after
    a_reset_quiet: assert property (@(posedge clock_50)
        !key0 |=> (!rd_valid && !uart_valid && irq_vector == 4'd0
                   && bus_rdata == '0 && uart_data == '0))
    else begin
        $error("outputs not cleared by reset");
        fail_count++;
    end

endmodule

/* dv/soc_bus_tb.sv */
`include "soc_cfg.svh"
`timescale 1ns/1ns

module soc_bus_tb;

    import soc_pkg::*;

    // Word offset inside the RAM window
    typedef logic [$clog2(`RAM_SIZE / 4)-1:0] word_off_t;

    logic       clock_50;
    logic       key0;
    addr_t      bus_addr;
    data_t      bus_wdata;
    logic       bus_wr;
    logic       bus_rd;
    data_t      bus_rdata;
    logic       rd_valid;
    logic       key_valid;
    key_code_t  key_code;
    logic [3:0] irq_vector;
    logic       irq_ack;
    logic       uart_valid;
    key_code_t  uart_data;

    // Reference model and expected responses
    data_t       shadow_mem [`RAM_SIZE / 4];
    key_code_t   key_last;
    data_t       rd_q [$];
    key_code_t   uart_q [$];
    data_t       rd_exp;
    key_code_t   uart_exp;
    logic [31:0] lfsr;
    int unsigned check_count;
    int unsigned error_count;
    int unsigned test_count;
    int unsigned test_start_errors;

    soc_bus_top i_dut (.*);

    bind soc_bus_top soc_bus_assert i_bus_assert (
        .clock_50   (clock_50),
        .key0       (key0),
        .bus_addr   (bus_addr),
        .bus_wr     (bus_wr),
        .bus_rd     (bus_rd),
        .bus_rdata  (bus_rdata),
        .rd_valid   (rd_valid),
        .uart_valid (uart_valid),
        .uart_data  (uart_data),
        .irq_ack    (irq_ack),
        .irq_vector (irq_vector)
    );

    initial begin
        clock_50 = 1'b0;
        forever begin
            #5 clock_50 = ~clock_50;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    // One step per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int unsigned i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic in_ram(input addr_t addr);
        return (addr >= `RAM_BASE) && (addr < `RAM_BASE + `RAM_SIZE);
    endfunction

    task automatic check_value(input string name, input data_t got, input data_t exp);
        check_count++;
        assert (got == exp) else begin
            $display("Fail %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic bus_write(input addr_t addr, input data_t data);
        @(posedge clock_50);
        bus_addr  <= addr;
        bus_wdata <= data;
        bus_wr    <= 1'b1;
        bus_rd    <= 1'b0;
        if (in_ram(addr)) begin
            shadow_mem[word_off_t'((addr - `RAM_BASE) >> 2)] = data;
        end
        if (addr == `UART_ADDR) begin
            uart_q.push_back(data[7:0]);
        end
    endtask

    task automatic bus_read(input addr_t addr);
        @(posedge clock_50);
        bus_addr <= addr;
        bus_wr   <= 1'b0;
        bus_rd   <= 1'b1;
        if (in_ram(addr)) begin
            rd_q.push_back(shadow_mem[word_off_t'((addr - `RAM_BASE) >> 2)]);
        end else if (addr == `KEY_ADDR) begin
            rd_q.push_back(data_t'(key_last));
        end else begin
            // Holes and the console register answer zero
            rd_q.push_back('0);
        end
    endtask

    task automatic drive_key(input logic press, input key_code_t code, input logic ack);
        @(posedge clock_50);
        key_valid <= press;
        key_code  <= code;
        irq_ack   <= ack;
        if (press) begin
            key_last = code;
        end
        @(posedge clock_50);
        key_valid <= 1'b0;
        irq_ack   <= 1'b0;
    endtask

    task automatic expect_irq(input logic [3:0] exp);
        int unsigned cycles;
        cycles = 0;
        @(negedge clock_50);
        while (irq_vector != exp && cycles < 8) begin
            @(negedge clock_50);
            cycles++;
        end
        check_value("irq_vector", data_t'(irq_vector), data_t'(exp));
    endtask

    // Idle the bus and let every outstanding response arrive
    task automatic wait_drained();
        int unsigned cycles;
        cycles = 0;
        @(posedge clock_50);
        bus_wr <= 1'b0;
        bus_rd <= 1'b0;
        while ((rd_q.size() != 0 || uart_q.size() != 0) && cycles < 20) begin
            @(posedge clock_50);
            cycles++;
        end
        if (rd_q.size() != 0 || uart_q.size() != 0) begin
            $display("Timeout with %0d reads and %0d console writes unanswered",
                     rd_q.size(), uart_q.size());
            error_count++;
            rd_q.delete();
            uart_q.delete();
        end
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("Test %0d %s done, %0d errors", test_count, name,
                 error_count - test_start_errors);
        test_start_errors = error_count;
    endtask

    // Responses come back in issue order
    always @(negedge clock_50) begin
        if (key0 && rd_valid) begin
            if (rd_q.size() == 0) begin
                $display("rd_valid arrived with no read outstanding");
                error_count++;
            end else begin
                rd_exp = rd_q.pop_front();
                check_value("bus_rdata", bus_rdata, rd_exp);
            end
        end
    end

    always @(negedge clock_50) begin
        if (key0 && uart_valid) begin
            if (uart_q.size() == 0) begin
                $display("uart_valid arrived with no console write outstanding");
                error_count++;
            end else begin
                uart_exp = uart_q.pop_front();
                check_value("uart_data", data_t'(uart_data), data_t'(uart_exp));
            end
        end
    end

    initial begin
        addr_t     addr_list [16];
        addr_t     addr;
        key_code_t code;
        lfsr              = 32'd88895;
        check_count       = 0;
        error_count       = 0;
        test_count        = 0;
        test_start_errors = 0;
        key_last          = '0;
        for (int i = 0; i < `RAM_SIZE / 4; i++) begin
            shadow_mem[i] = '0;
        end
        key0      <= 1'b0;
        bus_addr  <= '0;
        bus_wdata <= '0;
        bus_wr    <= 1'b0;
        bus_rd    <= 1'b0;
        key_valid <= 1'b0;
        key_code  <= '0;
        irq_ack   <= 1'b0;
        repeat (5) @(posedge clock_50);
        key0 <= 1'b1;

        // Quiet outputs and cleared banks and key register
        @(negedge clock_50);
        check_value("rd_valid", data_t'(rd_valid), '0);
        check_value("uart_valid", data_t'(uart_valid), '0);
        check_value("irq_vector", data_t'(irq_vector), '0);
        for (int i = 0; i < `NUM_BANKS; i++) begin
            bus_read(`RAM_BASE + 32'(4 * i));
        end
        bus_read(`KEY_ADDR);
        wait_drained();
        finish_test("reset");

        // Random writes across the banks
        for (int i = 0; i < 16; i++) begin
            addr_list[i] = `RAM_BASE + (rand_bits($clog2(`RAM_SIZE / 4)) << 2);
            bus_write(addr_list[i], rand_bits(32));
        end
        // Pipelined readback
        for (int i = 0; i < 16; i++) begin
            bus_read(addr_list[i]);
        end
        // Write followed at once by a read of the same word
        for (int i = 0; i < 8; i++) begin
            addr = `RAM_BASE + (rand_bits($clog2(`RAM_SIZE / 4)) << 2);
            bus_write(addr, rand_bits(32));
            bus_read(addr);
        end
        wait_drained();
        finish_test("ram");

        // Holes around the map and the write-only console
        bus_read(`UART_ADDR);
        bus_read(32'h0000_0000);
        bus_read(`RAM_BASE - 32'd4);
        bus_read(`UART_ADDR + 32'd4);
        bus_read(32'h0000_3000);
        wait_drained();
        finish_test("unmapped");

        for (int i = 0; i < 6; i++) begin
            bus_write(`UART_ADDR, rand_bits(32));
        end
        wait_drained();
        finish_test("console");

        // Zero code latches but raises nothing
        drive_key(1'b1, '0, 1'b0);
        expect_irq(4'd0);
        bus_read(`KEY_ADDR);
        wait_drained();
        code = key_code_t'(rand_bits(8)) | 8'h01;
        drive_key(1'b1, code, 1'b0);
        expect_irq(4'd1);
        bus_read(`KEY_ADDR);
        wait_drained();
        finish_test("keyboard");

        drive_key(1'b0, '0, 1'b1);
        expect_irq(4'd0);
        drive_key(1'b1, key_code_t'(rand_bits(8)) | 8'h01, 1'b0);
        expect_irq(4'd1);
        // Ack together with a fresh key while pending and again while clear
        drive_key(1'b1, key_code_t'(rand_bits(8)) | 8'h01, 1'b1);
        expect_irq(4'd0);
        drive_key(1'b1, key_code_t'(rand_bits(8)) | 8'h01, 1'b1);
        expect_irq(4'd0);
        bus_read(`KEY_ADDR);
        wait_drained();
        finish_test("acknowledge");

        error_count += i_dut.i_bus_assert.fail_count;
        $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+hdl
hdl/soc_pkg.sv
hdl/bus_decoder.sv
hdl/ram_bank.sv
hdl/read_mux.sv
hdl/io_regs.sv
hdl/soc_bus_top.sv
dv/soc_bus_assert.sv
dv/soc_bus_tb.sv

/* Makefile */
SOURCES := $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)

all: run

obj_dir/Vsoc_bus_tb: project.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
		-f project.f --top-module soc_bus_tb -o Vsoc_bus_tb

run: obj_dir/Vsoc_bus_tb
	@out="$$(./obj_dir/Vsoc_bus_tb +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf obj_dir

.PHONY: all run clean
